// ==== sram_system.f ====
design/sram_pkg.sv
design/sram_req_if.sv
design/wb_request_queue.sv
design/sram_sequencer.sv
design/wb_ack_return.sv
design/sram_system.sv
verification/sram_model.sv
verification/sram_system_assertions.sv
verification/sram_system_tb.sv

// ==== verification/sram_system_tb.sv ====
module sram_system_tb;

    import sram_pkg::*;

    localparam int SEED         = 44;
    localparam int POOL_WORDS   = 16;
    localparam int BURST_COUNT  = 40;
    localparam int WAIT_LIMIT   = 200;
    localparam int QUIET_CYCLES = 8;

    logic       clk;
    logic       i_reset;
    logic       i_wb_cyc;
    logic       i_wb_stb;
    logic       i_wb_we;
    wb_sel_t    i_wb_sel;
    wb_addr_t   i_wb_addr;
    wb_data_t   i_wb_data;
    logic       o_wb_stall;
    logic       o_wb_ack;
    wb_data_t   o_wb_data;
    sram_addr_t o_sram_addr;
    wb_data_t   i_sram_dq;
    wb_data_t   o_sram_dq;
    logic       o_sram_ce_n;
    logic       o_sram_we_n;
    logic       o_sram_oe_n;
    logic       o_sram_ub_n;
    logic       o_sram_lb_n;

    integer     seed;
    integer     accepted_count;
    integer     ack_count;
    logic       stall_seen;
    wb_data_t   ref_mem [sram_addr_t];
    wb_data_t   expected_q [$];

    sram_system u_dut (.*);

    sram_model u_sram (
        .i_addr(o_sram_addr),
        .i_dq(o_sram_dq),
        .i_ce_n(o_sram_ce_n),
        .i_we_n(o_sram_we_n),
        .i_oe_n(o_sram_oe_n),
        .i_ub_n(o_sram_ub_n),
        .i_lb_n(o_sram_lb_n),
        .o_dq(i_sram_dq)
    );

    bind sram_system sram_system_assertions u_assertions (
        .clk(clk),
        .i_reset(i_reset),
        .i_wb_cyc(i_wb_cyc),
        .i_wb_stb(i_wb_stb),
        .i_wb_stall(o_wb_stall),
        .i_wb_ack(o_wb_ack),
        .i_sram_we_n(o_sram_we_n),
        .i_sram_oe_n(o_sram_oe_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input wb_data_t actual, input wb_data_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_count(input string name, input integer actual, input integer expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                               $time, name, actual, expected));
        end
    endtask

    // the pool spreads over the whole SRAM, and its last word is the top one.
    function automatic wb_addr_t pool_addr(input int index);
        return WINDOW_BASE + wb_addr_t'(index) * 32'h0001_1111;
    endfunction

    function automatic logic in_window(input wb_addr_t addr);
        return (addr >= WINDOW_BASE) &&
               ((addr - WINDOW_BASE) < (wb_addr_t'(1) << $bits(sram_addr_t)));
    endfunction

    // reference model update, taken in acceptance order.
    task automatic record_request();
        sram_addr_t word_addr;
        wb_data_t   old_word;
        wb_data_t   expected;

        expected  = '0;
        word_addr = sram_addr_t'(i_wb_addr - WINDOW_BASE);
        if (in_window(i_wb_addr)) begin
            old_word = ref_mem.exists(word_addr) ? ref_mem[word_addr] : 'x;
            if (i_wb_we) begin
                ref_mem[word_addr] = {i_wb_sel[1] ? i_wb_data[15:8] : old_word[15:8],
                                      i_wb_sel[0] ? i_wb_data[7:0] : old_word[7:0]};
            end else begin
                expected = {i_wb_sel[1] ? old_word[15:8] : 8'h00,
                            i_wb_sel[0] ? old_word[7:0] : 8'h00};
            end
        end
        expected_q.push_back(expected);
        accepted_count = accepted_count + 1;
    endtask

    always @(posedge clk) begin
        if (!i_reset) begin
            if (o_wb_ack) begin
                if (expected_q.size() == 0) begin
                    fail_run("an ack arrived with no request outstanding");
                end
                check_data("o_wb_data", o_wb_data, expected_q.pop_front());
                ack_count = ack_count + 1;
            end
            if (o_wb_stall) begin
                stall_seen = 1'b1;
            end
            if (i_wb_cyc && i_wb_stb && !o_wb_stall) begin
                record_request();
            end
        end
    end

    // entered on a falling edge and returns on the falling edge after acceptance.
    task automatic drive_request(input logic we, input wb_sel_t sel,
                                 input wb_addr_t addr, input wb_data_t data);
        int waited;

        waited    = 0;
        i_wb_cyc  = 1'b1;
        i_wb_stb  = 1'b1;
        i_wb_we   = we;
        i_wb_sel  = sel;
        i_wb_addr = addr;
        i_wb_data = data;
        while (o_wb_stall) begin
            if (waited == WAIT_LIMIT) begin
                fail_run("stall stayed high and the request was never accepted");
            end
            @(negedge clk);
            waited = waited + 1;
        end
        @(negedge clk);
    endtask

    task automatic wait_for_acks();
        int waited;

        waited   = 0;
        i_wb_stb = 1'b0;
        while (ack_count != accepted_count) begin
            if (waited == WAIT_LIMIT) begin
                fail_run("timed out waiting for the outstanding acks");
            end
            @(negedge clk);
            waited = waited + 1;
        end
        i_wb_cyc = 1'b0;
    endtask

    initial begin
        integer  pick;
        wb_sel_t sel;

        seed           = SEED;
        accepted_count = 0;
        ack_count      = 0;
        stall_seen     = 1'b0;
        i_reset        = 1'b1;
        i_wb_cyc       = 1'b0;
        i_wb_stb       = 1'b0;
        i_wb_we        = 1'b0;
        i_wb_sel       = '0;
        i_wb_addr      = '0;
        i_wb_data      = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;

        check_flag("o_wb_ack", o_wb_ack, 1'b0);
        check_flag("o_wb_stall", o_wb_stall, 1'b0);
        check_flag("o_sram_ce_n", o_sram_ce_n, 1'b1);
        check_flag("o_sram_we_n", o_sram_we_n, 1'b1);
        check_flag("o_sram_oe_n", o_sram_oe_n, 1'b1);
        check_flag("o_sram_ub_n", o_sram_ub_n, 1'b1);
        check_flag("o_sram_lb_n", o_sram_lb_n, 1'b1);

        for (int i = 0; i < POOL_WORDS; i++) begin
            drive_request(1'b1, 2'b11, pool_addr(i), wb_data_t'($random(seed)));
        end
        for (int i = 0; i < POOL_WORDS; i++) begin
            drive_request(1'b0, 2'b11, pool_addr(i), '0);
        end
        wait_for_acks();

        // byte writes, then full reads show the untouched lane.
        for (int i = 0; i < 4; i++) begin
            sel = (i % 2 == 0) ? 2'b01 : 2'b10;
            drive_request(1'b1, sel, pool_addr(i), wb_data_t'($random(seed)));
        end
        for (int i = 0; i < 4; i++) begin
            drive_request(1'b0, 2'b11, pool_addr(i), '0);
        end
        for (int i = 4; i < 8; i++) begin
            sel = (i % 2 == 0) ? 2'b01 : 2'b10;
            drive_request(1'b0, sel, pool_addr(i), '0);
        end
        wait_for_acks();

        // these wrap onto pool words 0 and 15 if the window check is lost.
        drive_request(1'b1, 2'b11, WINDOW_BASE + 32'h0010_0000, 16'hdead);
        drive_request(1'b1, 2'b11, WINDOW_BASE - 1, 16'hbeef);
        drive_request(1'b0, 2'b11, WINDOW_BASE + 32'h0010_0000, '0);
        drive_request(1'b0, 2'b11, 32'hffff_ffff, '0);
        drive_request(1'b0, 2'b11, pool_addr(0), '0);
        drive_request(1'b0, 2'b11, pool_addr(POOL_WORDS - 1), '0);
        wait_for_acks();

        stall_seen = 1'b0;
        for (int i = 0; i < BURST_COUNT; i++) begin
            pick = $random(seed);
            if (pick[2:0] == 3'd0) begin
                drive_request(pick[12], wb_sel_t'(pick[9:8]),
                              wb_addr_t'($random(seed)) & 32'h0000_ffff,
                              wb_data_t'($random(seed)));
            end else begin
                drive_request(pick[12], wb_sel_t'(pick[9:8]), pool_addr(pick[7:4]),
                              wb_data_t'($random(seed)));
            end
        end
        wait_for_acks();

        // the bus then stays idle for a few cycles, so a late extra ack is still counted.
        repeat (QUIET_CYCLES) @(negedge clk);

        check_flag("stall during burst", stall_seen, 1'b1);
        check_count("ack count", ack_count, accepted_count);
        check_count("expected queue size", expected_q.size(), 0);

        if (u_dut.u_assertions.failure_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_run("assertion failures were reported during the run");
        end
    end

endmodule

// ==== verification/sram_system_assertions.sv ====
module sram_system_assertions (
    input logic clk,
    input logic i_reset,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_stall,
    input logic i_wb_ack,
    input logic i_sram_we_n,
    input logic i_sram_oe_n
);

    int outstanding;
    int failure_count = 0;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(i_wb_cyc && i_wb_stb && !i_wb_stall)
                           - int'(i_wb_ack);
        end
    end

    stb_needs_cyc: assert property (@(posedge clk) disable iff (i_reset)
        i_wb_stb |-> i_wb_cyc)
    else begin
        failure_count = failure_count + 1;
        $error("strobe raised without cycle");
    end

    // the data bus direction is set by we_n, so oe_n must stay off during writes.
    no_bus_contention: assert property (@(posedge clk) disable iff (i_reset)
        !(!i_sram_we_n && !i_sram_oe_n))
    else begin
        failure_count = failure_count + 1;
        $error("we_n and oe_n both low");
    end

    ack_needs_request: assert property (@(posedge clk) disable iff (i_reset)
        i_wb_ack |-> (outstanding != 0))
    else begin
        failure_count = failure_count + 1;
        $error("ack with nothing outstanding");
    end

    stall_low_after_reset: assert property (@(posedge clk)
        i_reset |=> !i_wb_stall)
    else begin
        failure_count = failure_count + 1;
        $error("stall high after reset");
    end

endmodule

// ==== verification/sram_model.sv ====
module sram_model (
    input  sram_pkg::sram_addr_t i_addr,
    input  sram_pkg::wb_data_t   i_dq,
    input  logic                 i_ce_n,
    input  logic                 i_we_n,
    input  logic                 i_oe_n,
    input  logic                 i_ub_n,
    input  logic                 i_lb_n,
    output sram_pkg::wb_data_t   o_dq
);

    import sram_pkg::*;

    wb_data_t mem [sram_addr_t];
    wb_data_t read_word;

    // address, data and lanes are set up a cycle before the write pulse,
    // so the word is stored as the pulse begins.
    always @(negedge i_we_n) begin
        wb_data_t word;

        if (!i_ce_n) begin
            word = mem.exists(i_addr) ? mem[i_addr] : 'x;
            if (!i_ub_n) begin
                word[15:8] = i_dq[15:8];
            end
            if (!i_lb_n) begin
                word[7:0] = i_dq[7:0];
            end
            mem[i_addr] = word;
        end
    end

    // disabled lanes float, as on the real part.
    always @(i_addr, i_ce_n, i_oe_n, i_ub_n, i_lb_n) begin
        wb_data_t stored;

        read_word = 'z;
        if (!i_ce_n && !i_oe_n) begin
            stored = mem.exists(i_addr) ? mem[i_addr] : 'x;
            if (!i_ub_n) begin
                read_word[15:8] = stored[15:8];
            end
            if (!i_lb_n) begin
                read_word[7:0] = stored[7:0];
            end
        end
    end

    assign o_dq = !i_we_n ? i_dq : read_word;

endmodule

// ==== design/sram_system.sv ====
module sram_system (
    input  logic                clk,
    input  logic                i_reset,

    // Wishbone slave port.
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  logic                i_wb_we,
    input  sram_pkg::wb_sel_t    i_wb_sel,
    input  sram_pkg::wb_addr_t   i_wb_addr,
    input  sram_pkg::wb_data_t   i_wb_data,
    output logic                o_wb_stall,
    output logic                o_wb_ack,
    output sram_pkg::wb_data_t   o_wb_data,

    // asynchronous SRAM pins, data bus split by direction.
    output sram_pkg::sram_addr_t o_sram_addr,
    input  sram_pkg::wb_data_t   i_sram_dq,
    output sram_pkg::wb_data_t   o_sram_dq,
    output logic                o_sram_ce_n,
    output logic                o_sram_we_n,
    output logic                o_sram_oe_n,
    output logic                o_sram_ub_n,
    output logic                o_sram_lb_n
);

    import sram_pkg::*;

    logic     seq_done;
    wb_data_t seq_rdata;
    wb_sel_t  seq_sel;

    sram_req_if req_if ();

    wb_request_queue wb_request_queue_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_wb_cyc(i_wb_cyc),
        .i_wb_stb(i_wb_stb),
        .i_wb_we(i_wb_we),
        .i_wb_sel(i_wb_sel),
        .i_wb_addr(i_wb_addr),
        .i_wb_data(i_wb_data),
        .o_wb_stall(o_wb_stall),
        .req(req_if.source)
    );

    sram_sequencer sram_sequencer_inst (
        .clk(clk),
        .i_reset(i_reset),
        .req(req_if.sink),
        .i_sram_dq(i_sram_dq),
        .o_sram_addr(o_sram_addr),
        .o_sram_dq(o_sram_dq),
        .o_sram_ce_n(o_sram_ce_n),
        .o_sram_we_n(o_sram_we_n),
        .o_sram_oe_n(o_sram_oe_n),
        .o_sram_ub_n(o_sram_ub_n),
        .o_sram_lb_n(o_sram_lb_n),
        .o_done(seq_done),
        .o_rdata(seq_rdata),
        .o_sel(seq_sel)
    );

    wb_ack_return wb_ack_return_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_done(seq_done),
        .i_rdata(seq_rdata),
        .i_sel(seq_sel),
        .o_wb_ack(o_wb_ack),
        .o_wb_data(o_wb_data)
    );

endmodule

// ==== design/wb_ack_return.sv ====
module wb_ack_return (
    input  logic              clk,
    input  logic              i_reset,

    input  logic              i_done,
    input  sram_pkg::wb_data_t i_rdata,
    input  sram_pkg::wb_sel_t  i_sel,

    output logic              o_wb_ack,
    output sram_pkg::wb_data_t o_wb_data
);

    import sram_pkg::*;

    wb_data_t masked_data;

    // clears every byte lane the master did not select.
    function automatic wb_data_t mask_lanes(wb_data_t data, wb_sel_t sel);
        wb_data_t result;

        result = '0;
        for (int lane = 0; lane < WB_SEL_WIDTH; lane++) begin
            if (sel[lane]) begin
                result[lane*BYTE_WIDTH +: BYTE_WIDTH] = data[lane*BYTE_WIDTH +: BYTE_WIDTH];
            end
        end

        return result;
    endfunction

    assign masked_data = mask_lanes(i_rdata, i_sel);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= i_done;
        end
    end

    // the last returned word stays on the bus until the next ack.
    always_ff @(posedge clk) begin
        if (i_done) begin
            o_wb_data <= masked_data;
        end
    end

endmodule

// ==== design/sram_sequencer.sv ====
module sram_sequencer (
    input  logic                clk,
    input  logic                i_reset,

    sram_req_if.sink            req,

    input  sram_pkg::wb_data_t   i_sram_dq,
    output sram_pkg::sram_addr_t o_sram_addr,
    output sram_pkg::wb_data_t   o_sram_dq,
    output logic                o_sram_ce_n,
    output logic                o_sram_we_n,
    output logic                o_sram_oe_n,
    output logic                o_sram_ub_n,
    output logic                o_sram_lb_n,

    output logic                o_done,
    output sram_pkg::wb_data_t   o_rdata,
    output sram_pkg::wb_sel_t    o_sel
);

    import sram_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    logic       we_q;
    logic       in_window_q;
    wb_sel_t    sel_q;
    logic       access_write;
    logic       access_read;

    // a new request can be taken from idle, or straight out of the access
    // phase so that back to back requests run every second cycle.
    assign req.take = req.valid && ((state == SEQ_IDLE) || (state == SEQ_ACCESS));

    assign access_write = (state == SEQ_SETUP) && in_window_q && we_q;
    assign access_read  = (state == SEQ_SETUP) && in_window_q && !we_q;

    always_comb begin
        state_next = state;

        unique case (state)
            SEQ_IDLE:   if (req.valid) state_next = SEQ_SETUP;
            SEQ_SETUP:  state_next = SEQ_ACCESS;
            SEQ_ACCESS: state_next = req.valid ? SEQ_SETUP : SEQ_IDLE;
            default:    state_next = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_sram_ce_n <= 1'b1;
            o_sram_we_n <= 1'b1;
            o_sram_oe_n <= 1'b1;
            o_sram_ub_n <= 1'b1;
            o_sram_lb_n <= 1'b1;
            o_done      <= 1'b0;
        end else begin
            o_done <= (state == SEQ_ACCESS);

            // out of window requests keep the chip and both lanes disabled.
            if (req.take) begin
                o_sram_ce_n <= !req.in_window;
                o_sram_ub_n <= !(req.in_window && req.sel[1]);
                o_sram_lb_n <= !(req.in_window && req.sel[0]);
            end else if (state == SEQ_ACCESS) begin
                o_sram_ce_n <= 1'b1;
                o_sram_ub_n <= 1'b1;
                o_sram_lb_n <= 1'b1;
            end

            o_sram_we_n <= !access_write;
            o_sram_oe_n <= !access_read;
        end
    end

    always_ff @(posedge clk) begin
        if (req.take) begin
            o_sram_addr <= req.sram_addr;
            o_sram_dq   <= req.wdata;
            we_q        <= req.we;
            in_window_q <= req.in_window;
            sel_q       <= req.sel;
        end

        // the read word is sampled at the end of the access phase.
        if (state == SEQ_ACCESS) begin
            o_rdata <= (in_window_q && !we_q) ? i_sram_dq : '0;
            o_sel   <= sel_q;
        end
    end

endmodule

// ==== design/wb_request_queue.sv ====
module wb_request_queue (
    input  logic              clk,
    input  logic              i_reset,

    input  logic              i_wb_cyc,
    input  logic              i_wb_stb,
    input  logic              i_wb_we,
    input  sram_pkg::wb_sel_t  i_wb_sel,
    input  sram_pkg::wb_addr_t i_wb_addr,
    input  sram_pkg::wb_data_t i_wb_data,
    output logic              o_wb_stall,

    sram_req_if.source        req
);

    import sram_pkg::*;

    logic         accept;
    logic         pop;
    logic         addr_in_window;
    sram_addr_t   addr_offset;

    queue_ptr_t   wr_ptr;
    queue_ptr_t   rd_ptr;
    queue_count_t count;

    logic         we_mem        [QUEUE_DEPTH];
    wb_sel_t      sel_mem       [QUEUE_DEPTH];
    logic         in_window_mem [QUEUE_DEPTH];
    sram_addr_t   addr_mem      [QUEUE_DEPTH];
    wb_data_t     wdata_mem     [QUEUE_DEPTH];

    assign o_wb_stall = (count == queue_count_t'(QUEUE_DEPTH));
    assign accept     = i_wb_cyc && i_wb_stb && !o_wb_stall;
    assign pop        = req.valid && req.take;

    // requests outside the window are still queued so that their ack
    // keeps its place in the response order.
    assign addr_in_window = (i_wb_addr >= WINDOW_BASE) &&
                            (i_wb_addr < (WINDOW_BASE + WINDOW_WORDS));
    assign addr_offset    = sram_addr_t'(i_wb_addr - WINDOW_BASE);

    assign req.valid     = (count != '0);
    assign req.we        = we_mem[rd_ptr];
    assign req.sel       = sel_mem[rd_ptr];
    assign req.in_window = in_window_mem[rd_ptr];
    assign req.sram_addr = addr_mem[rd_ptr];
    assign req.wdata     = wdata_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (accept) begin
            we_mem[wr_ptr]        <= i_wb_we;
            sel_mem[wr_ptr]       <= i_wb_sel;
            in_window_mem[wr_ptr] <= addr_in_window;
            addr_mem[wr_ptr]      <= addr_offset;
            wdata_mem[wr_ptr]     <= i_wb_data;
        end
    end

    // pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            count <= '0;
        end else begin
            unique case ({accept, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/sram_req_if.sv ====
interface sram_req_if;

    import sram_pkg::*;

    // head entry of the request queue, presented while valid is high.
    logic       valid;
    logic       take;
    logic       we;
    wb_sel_t    sel;
    logic       in_window;
    sram_addr_t sram_addr;
    wb_data_t   wdata;

    modport source (
        output valid,
        output we,
        output sel,
        output in_window,
        output sram_addr,
        output wdata,
        input  take
    );

    modport sink (
        input  valid,
        input  we,
        input  sel,
        input  in_window,
        input  sram_addr,
        input  wdata,
        output take
    );

endinterface

// ==== design/sram_pkg.sv ====
package sram_pkg;

    // widths of the Wishbone side and the asynchronous SRAM side.
    localparam int WB_ADDR_WIDTH   = 32;
    localparam int WB_DATA_WIDTH   = 16;
    localparam int BYTE_WIDTH      = 8;
    localparam int WB_SEL_WIDTH    = WB_DATA_WIDTH / BYTE_WIDTH;
    localparam int SRAM_ADDR_WIDTH = 20;

    typedef logic [WB_ADDR_WIDTH-1:0]   wb_addr_t;
    typedef logic [WB_DATA_WIDTH-1:0]   wb_data_t;
    typedef logic [WB_SEL_WIDTH-1:0]    wb_sel_t;
    typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;

    // word address that maps onto SRAM word 0.
    localparam wb_addr_t WINDOW_BASE = 32'h0001_0000;

    // the window covers the whole SRAM, one Wishbone word per SRAM word.
    localparam wb_addr_t WINDOW_WORDS = wb_addr_t'(1) << SRAM_ADDR_WIDTH;

    // request queue between the bus side and the sequencer.
    localparam int QUEUE_DEPTH     = 8;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);

    typedef logic [QUEUE_PTR_WIDTH-1:0] queue_ptr_t;

    // one extra bit so that a full queue can be told from an empty one.
    typedef logic [QUEUE_PTR_WIDTH:0]   queue_count_t;

    // each request spends one cycle in setup and one in access.
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SETUP,
        SEQ_ACCESS
    } seq_state_t;

endpackage
